/* design/seq_pkg.sv */
// ----------------------------------------
// Shared sizing, types and helpers for the
// sequence-number tracker; every module
// pulls these in by wildcard import
// ----------------------------------------

package seq_pkg;

  // ----------------------------------------
  // Sizing
  // ----------------------------------------

  // Sequence number and its epoch split
  localparam int SEQ_NUM_BITS     = 5;
  localparam int EPOCH_BITS       = 2;
  localparam int SEQ_IDX_BITS     = SEQ_NUM_BITS - EPOCH_BITS;
  localparam int NUM_ENTRIES      = 2 ** SEQ_NUM_BITS;

  // Tail retires at most this many per cycle
  localparam int RECLAIM_WIDTH    = 2;

  // Completion side
  localparam int NUM_COMP_PORTS   = 2;
  localparam int COMP_QUEUE_DEPTH = 4;
  localparam int CQ_PTR_BITS      = $clog2(COMP_QUEUE_DEPTH);
  localparam int PORT_IDX_BITS    = $clog2(NUM_COMP_PORTS);

  // ----------------------------------------
  // Types
  // ----------------------------------------

  typedef logic [SEQ_NUM_BITS-1:0]  seq_num_t;
  typedef logic [EPOCH_BITS-1:0]    epoch_t;
  typedef logic [SEQ_IDX_BITS-1:0]  seq_idx_t;
  typedef logic [CQ_PTR_BITS-1:0]   cq_ptr_t;
  // One extra bit so a full queue is countable
  typedef logic [CQ_PTR_BITS:0]     cq_count_t;
  typedef logic [PORT_IDX_BITS-1:0] port_idx_t;

  // One free per cycle into the unit
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
  } free_req_t;

  // Epoch is the top bits of a number
  function automatic epoch_t get_epoch(input seq_num_t seq_num);
    return seq_num[SEQ_NUM_BITS-1 -: EPOCH_BITS];
  endfunction

  // Index within the epoch is the rest
  function automatic seq_idx_t get_idx(input seq_num_t seq_num);
    return seq_num[SEQ_IDX_BITS-1:0];
  endfunction

endpackage

/* design/sequencing_unit.sv */
// ----------------------------------------
// Hands out sequence numbers in order,
// marks returned numbers free and moves
// the tail over freed entries in order
// ----------------------------------------

`timescale 1ns/1ns

module sequencing_unit import seq_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Allocation, head advances on avail and take
  input  logic      alloc_take,
  output logic      alloc_avail,
  output seq_num_t  alloc_seq_num,

  // Free strobe from the arbiter
  input  free_req_t free_req,

  // Epoch of the oldest live number
  output epoch_t    tail_epoch
);

  // ----------------------------------------
  // State
  // ----------------------------------------

  seq_num_t head_ptr;
  seq_num_t tail_ptr;

  // One bit per entry, set while the number is live
  logic [NUM_ENTRIES-1:0] entry_alloc;

  seq_num_t entries_allocated;
  seq_num_t tail_incr;
  epoch_t   head_epoch;
  seq_idx_t head_idx;
  logic     is_alloc;

  // Per slot ahead of the tail, reclaimable on its own
  logic [RECLAIM_WIDTH-1:0] reclaim_ok;

  assign head_epoch = get_epoch(head_ptr);
  assign head_idx   = get_idx(head_ptr);
  assign tail_epoch = get_epoch(tail_ptr);

  // Live span between tail and head
  assign entries_allocated = head_ptr - tail_ptr;

  // ----------------------------------------
  // Allocation
  // ----------------------------------------

  // Stop at the last index of an epoch when the
  // next epoch is still held by the tail
  assign alloc_avail = !((head_idx == '1) &&
                         ((head_epoch + epoch_t'(1)) == tail_epoch));

  assign alloc_seq_num = head_ptr;
  assign is_alloc      = alloc_avail && alloc_take;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
    end else if (is_alloc) begin
      head_ptr <= head_ptr + seq_num_t'(1);
    end
  end

  // ----------------------------------------
  // Entry marking
  // ----------------------------------------

  // Head slot is always outside the live span,
  // so alloc and free never hit the same entry
  always_ff @(posedge clk) begin
    if (rst) begin
      entry_alloc <= '0;
    end else begin
      if (is_alloc) begin
        entry_alloc[head_ptr] <= 1'b1;
      end
      if (free_req.val) begin
        entry_alloc[free_req.seq_num] <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Reclaim
  // ----------------------------------------

  // Slot i qualifies when freed and still inside the live span
  for (genvar i = 0; i < RECLAIM_WIDTH; i++) begin : g_scan
    seq_num_t scan_ptr;

    assign scan_ptr      = tail_ptr + seq_num_t'(i);
    assign reclaim_ok[i] = !entry_alloc[scan_ptr] &&
                           (seq_num_t'(i) < entries_allocated);
  end

  // Length of the unbroken run from the tail
  always_comb begin : reclaim_count
    logic run_open;

    run_open  = 1'b1;
    tail_incr = '0;
    for (int i = 0; i < RECLAIM_WIDTH; i++) begin
      run_open = run_open && reclaim_ok[i];
      if (run_open) begin
        tail_incr = tail_incr + seq_num_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr <= '0;
    end else begin
      tail_ptr <= tail_ptr + tail_incr;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Completions only return numbers that are live
  a_free_live: assert property (
    @(posedge clk) disable iff (rst)
    free_req.val |-> entry_alloc[free_req.seq_num]
  ) else $error("free of entry %0d that is not live", free_req.seq_num);

  // Tail may close the gap to the old head but never cross it
  a_tail_behind_head: assert property (
    @(posedge clk) disable iff (rst)
    1'b1 |=> (seq_num_t'($past(head_ptr) - tail_ptr) <= $past(entries_allocated))
  ) else $error("tail moved past head");

endmodule

/* design/completion_queue.sv */
// ----------------------------------------
// Small FIFO of finished numbers for one
// completion port, popped by arbiter grant
// ----------------------------------------

`timescale 1ns/1ns

module completion_queue import seq_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  seq_num_t push_seq_num,
  output logic     full,
  output logic     req,
  output seq_num_t head_seq_num,
  input  logic     grant
);

  // Storage and pointers
  seq_num_t  mem [COMP_QUEUE_DEPTH];
  cq_ptr_t   wr_ptr;
  cq_ptr_t   rd_ptr;
  cq_count_t count;

  logic do_push;
  logic do_pop;

  // ----------------------------------------
  // Status
  // ----------------------------------------

  assign full         = (count == cq_count_t'(COMP_QUEUE_DEPTH));
  assign req          = (count != '0);
  assign head_seq_num = mem[rd_ptr];

  // Overflow push is dropped
  assign do_push = push && !full;
  assign do_pop  = grant && req;

  // ----------------------------------------
  // Pointers and count
  // ----------------------------------------

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + cq_ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + cq_ptr_t'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + cq_count_t'(1);
        2'b01:   count <= count - cq_count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_seq_num;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst) push |-> !full
  ) else $error("push into full completion queue");

  // Arbiter must only grant a requesting queue
  a_no_grant_empty: assert property (
    @(posedge clk) disable iff (rst) grant |-> req
  ) else $error("grant to empty completion queue");

endmodule

/* design/free_arbiter.sv */
// ----------------------------------------
// Round-robin pick between the completion
// queue heads, drives the single free strobe
// ----------------------------------------

`timescale 1ns/1ns

module free_arbiter import seq_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic     [NUM_COMP_PORTS-1:0]  req,
  input  seq_num_t [NUM_COMP_PORTS-1:0]  head_seq_num,
  output logic     [NUM_COMP_PORTS-1:0]  grant,
  output free_req_t                      free_req
);

  // Last winner gets lowest priority next time
  port_idx_t last_winner;
  port_idx_t winner;
  logic      found;

  // ----------------------------------------
  // Pick
  // ----------------------------------------

  // Scan from the port after the last winner
  always_comb begin : pick
    port_idx_t cand;

    found  = 1'b0;
    winner = last_winner;
    grant  = '0;
    for (int k = 1; k <= NUM_COMP_PORTS; k++) begin
      cand = port_idx_t'((int'(last_winner) + k) % NUM_COMP_PORTS);
      if (!found && req[cand]) begin
        found  = 1'b1;
        winner = cand;
      end
    end
    if (found) begin
      grant[winner] = 1'b1;
    end
  end

  assign free_req.val     = found;
  assign free_req.seq_num = head_seq_num[winner];

  // Reset to the top port so port 0 goes first
  always_ff @(posedge clk) begin
    if (rst) begin
      last_winner <= port_idx_t'(NUM_COMP_PORTS - 1);
    end else if (found) begin
      last_winner <= winner;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // One grant at most, only to a requester, none lost while any port asks
  a_grant_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~req) == '0) && ((req != '0) == (grant != '0))
  ) else $error("free grant not a single requesting port");

  // A loser that keeps requesting wins the next cycle
  for (genvar p = 0; p < NUM_COMP_PORTS; p++) begin : g_fair
    a_loser_next: assert property (
      @(posedge clk) disable iff (rst)
      (req[p] && !grant[p] && (grant != '0)) |=> (!req[p] || grant[p])
    ) else $error("port %0d starved", p);
  end

endmodule

/* design/age_compare.sv */
// ----------------------------------------
// Combinational age order of two live
// numbers, relative to the tail epoch
// ----------------------------------------

`timescale 1ns/1ns

module age_compare import seq_pkg::*; (
  input  epoch_t   tail_epoch,
  input  seq_num_t query_a,
  input  seq_num_t query_b,
  output logic     a_older
);

  // Epochs counted from the tail, wrap is mod 4
  epoch_t   rebased_a;
  epoch_t   rebased_b;
  seq_idx_t idx_a;
  seq_idx_t idx_b;

  // ----------------------------------------
  // Rebase
  // ----------------------------------------

  // Tail epoch becomes 0, later epochs count up from it
  assign rebased_a = get_epoch(query_a) - tail_epoch;
  assign rebased_b = get_epoch(query_b) - tail_epoch;

  assign idx_a = get_idx(query_a);
  assign idx_b = get_idx(query_b);

  // ----------------------------------------
  // Order
  // ----------------------------------------

  // Epoch first, index breaks the tie
  // Equal numbers are not older
  assign a_older = ({rebased_a, idx_a} < {rebased_b, idx_b});

endmodule

/* design/seq_tracker_top.sv */
// ----------------------------------------
// Top of the tracker, joins the sequencing
// unit, completion queues, arbiter and the
// age comparator
// ----------------------------------------

`timescale 1ns/1ns

module seq_tracker_top import seq_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,

  // Allocation
  input  logic                           alloc_take,
  output logic                           alloc_avail,
  output seq_num_t                       alloc_seq_num,

  // Completions, one lane per port
  input  logic     [NUM_COMP_PORTS-1:0]  comp_push,
  input  seq_num_t [NUM_COMP_PORTS-1:0]  comp_seq_num,
  output logic     [NUM_COMP_PORTS-1:0]  comp_full,

  // Age query
  input  seq_num_t                       query_a,
  input  seq_num_t                       query_b,
  output logic                           a_older,
  output epoch_t                         tail_epoch
);

  // Queue to arbiter
  logic     [NUM_COMP_PORTS-1:0] cq_req;
  logic     [NUM_COMP_PORTS-1:0] cq_grant;
  seq_num_t [NUM_COMP_PORTS-1:0] cq_head;

  // Arbiter to unit
  free_req_t free_req;

  sequencing_unit u_seq_unit (
    .clk           (clk),
    .rst           (rst),
    .alloc_take    (alloc_take),
    .alloc_avail   (alloc_avail),
    .alloc_seq_num (alloc_seq_num),
    .free_req      (free_req),
    .tail_epoch    (tail_epoch)
  );

  // One queue per completion port
  for (genvar p = 0; p < NUM_COMP_PORTS; p++) begin : g_cq
    completion_queue u_cq (
      .clk          (clk),
      .rst          (rst),
      .push         (comp_push[p]),
      .push_seq_num (comp_seq_num[p]),
      .full         (comp_full[p]),
      .req          (cq_req[p]),
      .head_seq_num (cq_head[p]),
      .grant        (cq_grant[p])
    );
  end

  free_arbiter u_free_arb (
    .clk          (clk),
    .rst          (rst),
    .req          (cq_req),
    .head_seq_num (cq_head),
    .grant        (cq_grant),
    .free_req     (free_req)
  );

  age_compare u_age_cmp (
    .tail_epoch (tail_epoch),
    .query_a    (query_a),
    .query_b    (query_b),
    .a_older    (a_older)
  );

endmodule

/* verif/seq_tracker_tb.sv */
// ----------------------------------------
// Directed testbench for the tracker top,
// tracks live numbers by allocation stamp
// ----------------------------------------

`timescale 1ns/1ns

module seq_tracker_tb import seq_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  // Whole run is near 250 cycles
  localparam int MAX_CYCLES   = 2000;
  // Tail retires two per cycle, 31 entries at most
  localparam int RECLAIM_WAIT = 40;

  logic                          clk;
  logic                          rst;
  logic                          alloc_take;
  logic                          alloc_avail;
  seq_num_t                      alloc_seq_num;
  logic     [NUM_COMP_PORTS-1:0] comp_push;
  seq_num_t [NUM_COMP_PORTS-1:0] comp_seq_num;
  logic     [NUM_COMP_PORTS-1:0] comp_full;
  seq_num_t                      query_a;
  seq_num_t                      query_b;
  logic                          a_older;
  epoch_t                        tail_epoch;

  int seed = 32'h5888;
  int errors;
  int tests_run;
  int tests_failed;
  int cycle_count;

  // Model, allocation stamp per live number, -1 when free
  int       stamp [NUM_ENTRIES];
  int       next_stamp;
  seq_num_t next_num;

  seq_tracker_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic report_mismatch(input string test, input string what,
                                 input int expected, input int actual);
    $display("[ERROR] %s: %s expected %0d, actual %0d", test, what, expected, actual);
    errors++;
  endtask

  task automatic finish_test(input string test, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", test);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", test, errors - errors_before);
    end
  endtask

  // Two reset cycles, model cleared with the DUT
  task automatic apply_reset();
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      stamp[seq_num_t'(i)] = -1;
    end
    next_stamp = 0;
    next_num   = '0;
  endtask

  // Hold take until max_n numbers come out or avail drops
  task automatic take_numbers(input string test, input int max_n, output int got);
    logic stopped;

    got     = 0;
    stopped = 1'b0;
    @(posedge clk);
    alloc_take <= 1'b1;
    while (got < max_n && !stopped) begin
      @(negedge clk);
      if (alloc_avail) begin
        if (alloc_seq_num !== next_num) begin
          report_mismatch(test, "alloc_seq_num", int'(next_num), int'(alloc_seq_num));
        end
        stamp[next_num] = next_stamp;
        next_stamp++;
        next_num++;
        got++;
      end else begin
        stopped = 1'b1;
      end
      @(posedge clk);
    end
    alloc_take <= 1'b0;
  endtask

  // One push, one idle cycle, so the queue never fills
  task automatic push_one(input logic port, input seq_num_t num);
    @(posedge clk);
    comp_push[port]    <= 1'b1;
    comp_seq_num[port] <= num;
    @(posedge clk);
    comp_push[port] <= 1'b0;
    stamp[num] = -1;
  endtask

  // Bounded wait for avail with the tail in its final epoch
  task automatic wait_reclaim(input string test, input epoch_t exp_epoch);
    int n;

    n = 0;
    @(negedge clk);
    while (!(alloc_avail && tail_epoch == exp_epoch) && n < RECLAIM_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (alloc_avail !== 1'b1) report_mismatch(test, "alloc_avail", 1, int'(alloc_avail));
    if (tail_epoch !== exp_epoch) begin
      report_mismatch(test, "tail_epoch", int'(exp_epoch), int'(tail_epoch));
    end
  endtask

  // Older means allocated earlier
  task automatic check_age(input seq_num_t a, input seq_num_t b);
    logic exp_older;

    exp_older = stamp[a] < stamp[b];
    @(posedge clk);
    query_a <= a;
    query_b <= b;
    @(negedge clk);
    if (a_older !== exp_older) begin
      report_mismatch("age_order", "a_older", int'(exp_older), int'(a_older));
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_reset_state();
    int e0;

    e0 = errors;
    @(negedge clk);
    if (alloc_avail !== 1'b1) report_mismatch("reset", "alloc_avail", 1, int'(alloc_avail));
    if (alloc_seq_num !== '0) report_mismatch("reset", "alloc_seq_num", 0, int'(alloc_seq_num));
    if (tail_epoch !== '0) report_mismatch("reset", "tail_epoch", 0, int'(tail_epoch));
    if (comp_full !== '0) report_mismatch("reset", "comp_full", 0, int'(comp_full));
    finish_test("reset", e0);
  endtask

  task automatic test_alloc_order();
    int e0;
    int got;

    e0 = errors;
    take_numbers("alloc_order", 8, got);
    if (got != 8) report_mismatch("alloc_order", "allocations", 8, got);
    finish_test("alloc_order", e0);
  endtask

  // Tail at 0, head must stop at the last slot of epoch 3
  task automatic test_wrap_limit();
    int e0;
    int got;

    e0 = errors;
    take_numbers("wrap_limit", NUM_ENTRIES + 8, got);
    if (next_stamp != NUM_ENTRIES - 1) begin
      report_mismatch("wrap_limit", "allocations", NUM_ENTRIES - 1, next_stamp);
    end
    @(negedge clk);
    if (alloc_avail !== 1'b0) report_mismatch("wrap_limit", "alloc_avail", 0, int'(alloc_avail));
    if (alloc_seq_num !== seq_num_t'(NUM_ENTRIES - 1)) begin
      report_mismatch("wrap_limit", "alloc_seq_num", NUM_ENTRIES - 1, int'(alloc_seq_num));
    end
    finish_test("wrap_limit", e0);
  endtask

  // Free 1..30 in random order, then 0 opens the run up to 31
  task automatic test_reclaim();
    seq_num_t pool [$];
    seq_num_t num;
    int       rnd;
    int       k;
    int       e0;

    e0 = errors;
    for (int i = 1; i < NUM_ENTRIES - 1; i++) begin
      pool.push_back(seq_num_t'(i));
    end
    while (pool.size() > 0) begin
      rnd = $random(seed);
      k   = $unsigned(rnd) % pool.size();
      num = pool[k];
      pool.delete(k);
      rnd = $random(seed);
      push_one(rnd[0], num);
    end
    // Number 0 still live, tail pinned
    repeat (4) begin
      @(negedge clk);
      if (alloc_avail !== 1'b0) report_mismatch("reclaim", "alloc_avail", 0, int'(alloc_avail));
      if (tail_epoch !== '0) report_mismatch("reclaim", "tail_epoch", 0, int'(tail_epoch));
    end
    push_one(1'b0, '0);
    // Tail catches the head at 31, epoch 3
    wait_reclaim("reclaim", epoch_t'(3));
    finish_test("reclaim", e0);
  endtask

  task automatic test_queue_full();
    logic [NUM_COMP_PORTS-1:0] seen_full;
    int                        got;
    int                        e0;

    e0 = errors;
    @(posedge clk);
    apply_reset();
    take_numbers("queue_full", NUM_ENTRIES, got);
    seen_full = '0;
    // Two pushes in, one free out per cycle; round robin from port 0
    // fills port 1 after six pushes each, port 0 after its seventh
    for (int c = 0; c < 9; c++) begin
      @(posedge clk);
      comp_push[0]    <= (c <= 6);
      comp_push[1]    <= (c <= 5);
      comp_seq_num[0] <= seq_num_t'(2 * c);
      comp_seq_num[1] <= seq_num_t'(2 * c + 1);
      if (c <= 6) stamp[seq_num_t'(2 * c)] = -1;
      if (c <= 5) stamp[seq_num_t'(2 * c + 1)] = -1;
      @(negedge clk);
      seen_full = seen_full | comp_full;
    end
    if (seen_full !== 2'b11) report_mismatch("queue_full", "comp_full seen", 3, int'(seen_full));
    // 0..12 freed, oldest live is 13 in epoch 1
    wait_reclaim("queue_full", epoch_t'(1));
    finish_test("queue_full", e0);
  endtask

  // Head wraps past 31 so raw order disagrees with age
  task automatic test_age_order();
    seq_num_t live [$];
    int       rnd;
    int       got;
    int       e0;

    e0 = errors;
    take_numbers("age_order", NUM_ENTRIES, got);
    check_age(seq_num_t'(2), seq_num_t'(20));
    check_age(seq_num_t'(31), seq_num_t'(0));
    check_age(seq_num_t'(13), seq_num_t'(13));
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stamp[seq_num_t'(i)] >= 0) live.push_back(seq_num_t'(i));
    end
    repeat (16) begin
      rnd = $random(seed);
      check_age(live[$unsigned(rnd) % live.size()], live[$unsigned(rnd >>> 8) % live.size()]);
    end
    finish_test("age_order", e0);
  endtask

  initial begin
    rst          = 1'b1;
    alloc_take   = 1'b0;
    comp_push    = '0;
    comp_seq_num = '0;
    query_a      = '0;
    query_b      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    apply_reset();
    test_reset_state();
    test_alloc_order();
    test_wrap_limit();
    test_reclaim();
    test_queue_full();
    test_age_order();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* seq_tracker.f */
design/seq_pkg.sv
design/sequencing_unit.sv
design/completion_queue.sv
design/free_arbiter.sv
design/age_compare.sv
design/seq_tracker_top.sv
verif/seq_tracker_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the tracker testbench with Verilator, run it, grade the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module seq_tracker_tb -f seq_tracker.f -o sim_seq_tracker

./obj_dir/sim_seq_tracker | tee sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
